// ==== all.f ====
verilog/drive_cfg_pkg.sv
verilog/drive_types_pkg.sv
verilog/disk_change.sv
verilog/mode_reset.sv
verilog/head_stepper.sv
verilog/track_loader.sv
verilog/drive_mech.sv
tb/tb_clkgen.sv
tb/drive_mech_tb.sv

// ==== Bender.yml ====
package:
  name: drive_mech

sources:
  - files:
      - verilog/drive_cfg_pkg.sv
      - verilog/drive_types_pkg.sv
      - verilog/disk_change.sv
      - verilog/mode_reset.sv
      - verilog/head_stepper.sv
      - verilog/track_loader.sv
      - verilog/drive_mech.sv
  - target: test
    files:
      - tb/tb_clkgen.sv
      - tb/drive_mech_tb.sv

// ==== tb/drive_mech_tb.sv ====
// drive mechanics testbench
// table of drive operations, storage responder model, final report
`timescale 1ns/1ns

module drive_mech_tb;
	import drive_cfg_pkg::*;
	import drive_types_pkg::*;

	localparam int NROWS = 24;
	localparam logic K_RD = 1'b0;
	localparam logic K_WR = 1'b1;

	typedef enum logic [3:0] {
		OP_MOUNT, OP_STEP_IN, OP_STEP_OUT, OP_SIDE, OP_WRITE, OP_IDLE, OP_MODE, OP_MOTOR, OP_SLOW
	} op_t;

	// one table row, expected transactions given as track numbers
	typedef struct packed {
		logic [3:0] op;
		logic [7:0] arg;
		logic [7:0] exp_track;
		logic [7:0] exp_cnt;
		logic       first_wr;
		logic [7:0] first_trk;
		logic       last_wr;
		logic [7:0] last_trk;
	} row_t;

	logic        clk;
	logic        reset;
	logic        tick;
	logic [1:0]  drv_mode;
	logic        mount;
	logic        img_readonly;
	logic [31:0] img_size;
	mech_ctrl_t  ctrl;
	logic        sd_ack;
	disk_stat_t  stat;
	sd_req_t     sd;
	logic [7:0]  track;
	logic        led;
	logic        drv_reset;

	row_t        rows [NROWS];
	logic [1:0]  cur_mode;
	int          slow_extra;
	int          seed = 70;
	int          mismatch_cnt;
	int          timeout_cnt;
	int          op_err_cnt;
	// storage transactions as seen by the responder
	logic        log_wr [$];
	logic [31:0] log_lba [$];

	tb_clkgen u_clkgen (.clk_o(clk), .reset_o(reset));

	drive_mech u_dut (
		.clk            (clk),
		.reset          (reset),
		.tick_i         (tick),
		.drv_mode_i     (drv_mode),
		.mount_i        (mount),
		.img_readonly_i (img_readonly),
		.img_size_i     (img_size),
		.ctrl_i         (ctrl),
		.sd_ack_i       (sd_ack),
		.stat_o         (stat),
		.sd_o           (sd),
		.track_o        (track),
		.led_o          (led),
		.drv_reset_o    (drv_reset)
	);

	// --------------------------------------------------
	// expected value helpers
	// --------------------------------------------------
	// track index from half-track and side
	function automatic logic [7:0] track_idx(input int half, input logic side);
		return 8'(half) + (side ? SIDE_OFFSET : 8'd0);
	endfunction

	// first block of a track in the image
	function automatic logic [31:0] lba_of(input logic [7:0] trk);
		logic [31:0] blk;
		blk = (cur_mode == MODE_1541) ? 32'(BLK_CNT_1541) : 32'(BLK_CNT_157X);
		return 32'(trk) * blk;
	endfunction

	function automatic row_t make_row(input logic [3:0] op, input logic [7:0] arg,
			input logic [7:0] trk, input logic [7:0] cnt, input logic fw,
			input logic [7:0] ft, input logic lw, input logic [7:0] lt);
		return {op, arg, trk, cnt, fw, ft, lw, lt};
	endfunction

	task automatic check_val(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			mismatch_cnt++;
			$display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic report_timeout(input string what);
		timeout_cnt++;
		$display("TIMEOUT: %s", what);
	endtask

	// idle once the LED stays dark for 8 cycles, act itself masked
	task automatic wait_idle();
		int quiet;
		int n;
		quiet = 0;
		n = 0;
		while (quiet < 8 && n < 600) begin
			@(negedge clk);
			if (led && !ctrl.act)
				quiet = 0;
			else
				quiet++;
			n++;
		end
		if (quiet < 8)
			report_timeout("storage side stayed busy after the operation");
	endtask

	// --------------------------------------------------
	// operations
	// --------------------------------------------------
	task automatic mount_image(input logic ro, input logic empty);
		int blink;
		int k;
		@(posedge clk);
		#1;
		img_readonly = ro;
		img_size     = empty ? 32'd0 : 32'd174848;
		mount        = 1'b1;
		// edge register plus latch
		repeat (2) @(posedge clk);
		@(negedge clk);
		check_val("stat_o.present", stat.present, !empty);
		check_val("stat_o.readonly", stat.readonly, ro);
		// counts 63..1 with bit 3 set, 4 cycles each
		blink = 0;
		for (k = 0; k < 300; k++) begin
			if (stat.write_protect != ro)
				blink++;
			@(negedge clk);
		end
		check_val("write_protect blink cycles", blink, 128);
		check_val("stat_o.write_protect", stat.write_protect, ro);
		@(posedge clk);
		#1 mount = 1'b0;
	endtask

	task automatic switch_mode(input logic [1:0] m);
		int n;
		int ticks;
		@(posedge clk);
		#1;
		drv_mode = m;
		cur_mode = m;
		n = 0;
		while (!drv_reset && n < 20) begin
			@(negedge clk);
			n++;
		end
		if (!drv_reset)
			report_timeout("drive reset did not rise after the mode change");
		// ticks seen while the drive is held
		ticks = 0;
		n = 0;
		while (drv_reset && n < 2000) begin
			if (tick)
				ticks++;
			@(negedge clk);
			n++;
		end
		if (drv_reset)
			report_timeout("drive reset did not fall after the mode change");
		check_val("drv_reset_o ticks", ticks, 32'(RESET_HOLD_TICKS) + 32'd1);
		check_val("sd_o.blk_cnt", sd.blk_cnt,
			(m == MODE_1541) ? BLK_CNT_1541 : BLK_CNT_157X);
	endtask

	// arg[6:0] steps, arg[7] steps in a burst without waiting for idle
	task automatic step_head(input logic dir_in, input logic [7:0] arg);
		int k;
		for (k = 0; k < arg[6:0]; k++) begin
			@(posedge clk);
			#1;
			if (arg[7] && k > 0)
				check_val("led_o", led, 1'b1);
			if (dir_in)
				ctrl.stp = ctrl.stp + 2'd1;
			else
				ctrl.stp = ctrl.stp - 2'd1;
			// act kept until the step has been taken
			repeat (3) @(posedge clk);
			#1 ctrl.act = 1'b0;
			if (arg[7])
				repeat (5) @(posedge clk);
			else
				wait_idle();
		end
	endtask

	task automatic pulse_write(input logic keep_act);
		@(posedge clk);
		#1;
		ctrl.act   = 1'b1;
		ctrl.write = 1'b1;
		@(posedge clk);
		#1;
		ctrl.write = 1'b0;
		ctrl.act   = keep_act;
	endtask

	// --------------------------------------------------
	// tick and storage responder
	// --------------------------------------------------
	initial begin
		tick = 1'b0;
		forever begin
			repeat (3) @(posedge clk);
			#1 tick = 1'b1;
			@(posedge clk);
			#1 tick = 1'b0;
		end
	end

	initial begin
		int delay;
		sd_ack = 1'b0;
		forever begin
			@(posedge clk);
			#1;
			if ((sd.rd || sd.wr) && !sd_ack) begin
				log_wr.push_back(sd.wr);
				log_lba.push_back(sd.lba);
				delay = 1 + ({$random(seed)} % 8);
				repeat (delay + slow_extra) @(posedge clk);
				#1 sd_ack = 1'b1;
				repeat (2) @(posedge clk);
				#1 sd_ack = 1'b0;
			end
		end
	end

	initial begin
		#400000;
		$display("TIMEOUT: simulation ran past its time limit");
		$display("Simulation finished: FAIL");
		$finish;
	end

	// --------------------------------------------------
	// main sequence
	// --------------------------------------------------
	initial begin
		int   i;
		int   n;
		row_t r;
		drv_mode     = MODE_1541;
		cur_mode     = MODE_1541;
		mount        = 1'b0;
		img_readonly = 1'b0;
		img_size     = '0;
		ctrl         = '0;
		slow_extra   = 0;
		mismatch_cnt = 0;
		timeout_cnt  = 0;
		op_err_cnt   = 0;

		// mounts, then steps and clamps in 1541 mode
		rows[0]  = make_row(OP_MOUNT, 8'd1, 8'd36, 8'd1, K_RD, 8'd36, K_RD, 8'd36);
		rows[1]  = make_row(OP_MOUNT, 8'd2, 8'd36, 8'd1, K_RD, 8'd36, K_RD, 8'd36);
		rows[2]  = make_row(OP_MOTOR, 8'd1, 8'd36, 8'd0, K_RD, 8'd0, K_RD, 8'd0);
		rows[3]  = make_row(OP_IDLE, 8'd20, 8'd36, 8'd0, K_RD, 8'd0, K_RD, 8'd0);
		rows[4]  = make_row(OP_STEP_IN, 8'd1, 8'd37, 8'd1, K_RD, 8'd37, K_RD, 8'd37);
		rows[5]  = make_row(OP_STEP_OUT, 8'd2, 8'd35, 8'd2, K_RD, 8'd36, K_RD, 8'd35);
		rows[6]  = make_row(OP_STEP_OUT, 8'd40, 8'd0, 8'd35, K_RD, 8'd34, K_RD, 8'd0);
		rows[7]  = make_row(OP_STEP_IN, 8'd90, 8'd84, 8'd84, K_RD, 8'd1, K_RD, 8'd84);
		// 157x mode, motor off, side 1, dirty tracks
		rows[8]  = make_row(OP_MODE, {6'd0, MODE_1571}, 8'd36, 8'd0, K_RD, 8'd0, K_RD, 8'd0);
		rows[9]  = make_row(OP_MOTOR, 8'd0, 8'd36, 8'd0, K_RD, 8'd0, K_RD, 8'd0);
		rows[10] = make_row(OP_STEP_IN, 8'd3, 8'd36, 8'd0, K_RD, 8'd0, K_RD, 8'd0);
		rows[11] = make_row(OP_MOTOR, 8'd1, 8'd36, 8'd0, K_RD, 8'd0, K_RD, 8'd0);
		rows[12] = make_row(OP_SIDE, 8'd1, track_idx(36, 1), 8'd1,
			K_RD, track_idx(36, 1), K_RD, track_idx(36, 1));
		rows[13] = make_row(OP_STEP_IN, 8'd1, track_idx(37, 1), 8'd1,
			K_RD, track_idx(37, 1), K_RD, track_idx(37, 1));
		rows[14] = make_row(OP_WRITE, 8'd1, track_idx(37, 1), 8'd0, K_RD, 8'd0, K_RD, 8'd0);
		rows[15] = make_row(OP_STEP_OUT, 8'd1, track_idx(36, 1), 8'd2,
			K_WR, track_idx(37, 1), K_RD, track_idx(36, 1));
		rows[16] = make_row(OP_WRITE, 8'd0, track_idx(36, 1), 8'd1,
			K_WR, track_idx(36, 1), K_WR, track_idx(36, 1));
		rows[17] = make_row(OP_SIDE, 8'd0, 8'd36, 8'd1, K_RD, 8'd36, K_RD, 8'd36);
		// slow storage, burst of three steps merges the loads
		rows[18] = make_row(OP_SLOW, 8'd30, 8'd36, 8'd0, K_RD, 8'd0, K_RD, 8'd0);
		rows[19] = make_row(OP_WRITE, 8'd1, 8'd36, 8'd0, K_RD, 8'd0, K_RD, 8'd0);
		rows[20] = make_row(OP_STEP_IN, 8'h83, 8'd39, 8'd2, K_WR, 8'd36, K_RD, 8'd39);
		rows[21] = make_row(OP_SLOW, 8'd0, 8'd39, 8'd0, K_RD, 8'd0, K_RD, 8'd0);
		rows[22] = make_row(OP_MODE, {6'd0, MODE_1541}, 8'd36, 8'd0, K_RD, 8'd0, K_RD, 8'd0);
		rows[23] = make_row(OP_STEP_IN, 8'd2, 8'd38, 8'd2, K_RD, 8'd37, K_RD, 8'd38);

		@(negedge clk);
		check_val("drv_reset_o", drv_reset, 1'b1);
		n = 0;
		while (reset && n < 50) begin
			@(negedge clk);
			n++;
		end
		if (reset)
			report_timeout("reset was never released");
		check_val("sd_o.rd", sd.rd, 1'b0);
		check_val("sd_o.wr", sd.wr, 1'b0);
		check_val("led_o", led, 1'b0);
		check_val("drv_reset_o", drv_reset, 1'b0);
		check_val("track_o", track, 8'd36);

		for (i = 0; i < NROWS; i++) begin
			r = rows[i];
			log_wr.delete();
			log_lba.delete();
			case (r.op)
				OP_MOUNT:    mount_image(r.arg[0], r.arg[1]);
				OP_STEP_IN:  step_head(1'b1, r.arg);
				OP_STEP_OUT: step_head(1'b0, r.arg);
				OP_WRITE:    pulse_write(r.arg[0]);
				OP_MODE:     switch_mode(r.arg[1:0]);
				OP_IDLE:     repeat (r.arg) @(posedge clk);
				OP_SLOW:     slow_extra = r.arg;
				OP_SIDE: begin
					@(posedge clk);
					#1 ctrl.side = r.arg[0];
				end
				OP_MOTOR: begin
					@(posedge clk);
					#1 ctrl.mtr = r.arg[0];
				end
				default: begin
					op_err_cnt++;
					$display("ERROR: row %0d has an unknown operation", i);
				end
			endcase
			wait_idle();
			check_val("track_o", track, r.exp_track);
			check_val("transaction count", log_lba.size(), r.exp_cnt);
			// saves go first, so order shows in first and last
			if (log_lba.size() != 0 && r.exp_cnt != 0) begin
				check_val("first sd_o.wr", log_wr[0], r.first_wr);
				check_val("first sd_o.lba", log_lba[0], lba_of(r.first_trk));
				check_val("last sd_o.wr", log_wr[$], r.last_wr);
				check_val("last sd_o.lba", log_lba[$], lba_of(r.last_trk));
			end
		end

		$display("errors: %0d mismatches, %0d timeouts, %0d bad operations",
			mismatch_cnt, timeout_cnt, op_err_cnt);
		if (mismatch_cnt == 0 && timeout_cnt == 0 && op_err_cnt == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// ==== tb/tb_clkgen.sv ====
// testbench clock and reset source
// 4 ns clock, reset held high for the first 10 cycles
`timescale 1ns/1ns

module tb_clkgen (
	output logic clk_o,
	output logic reset_o
);

	initial begin
		clk_o   = 1'b0;
		reset_o = 1'b1;
		repeat (10) @(posedge clk_o);
		// release just after the edge like every other input
		#1 reset_o = 1'b0;
	end

	always #2 clk_o = ~clk_o;

endmodule

// ==== verilog/drive_mech.sv ====
// drive mechanics top level
// mode reset, disk change, head tracking and track storage for a 1541/157x drive
`timescale 1ns/1ns

module drive_mech (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        tick_i,
	input  logic [1:0]                  drv_mode_i,
	input  logic                        mount_i,
	input  logic                        img_readonly_i,
	input  logic [31:0]                 img_size_i,
	input  drive_types_pkg::mech_ctrl_t ctrl_i,
	input  logic                        sd_ack_i,
	output drive_types_pkg::disk_stat_t stat_o,
	output drive_types_pkg::sd_req_t    sd_o,
	output logic [7:0]                  track_o,
	output logic                        led_o,
	output logic                        drv_reset_o
);

	logic save_toggle;
	logic load_toggle;
	logic busy;

	// drive reset, also on a mode switch
	mode_reset u_mode_reset (
		.clk         (clk),
		.reset       (reset),
		.tick_i      (tick_i),
		.drv_mode_i  (drv_mode_i),
		.drv_reset_o (drv_reset_o)
	);

	// image status follows the host, not the drive reset
	disk_change u_disk_change (
		.clk            (clk),
		.reset          (reset),
		.tick_i         (tick_i),
		.mount_i        (mount_i),
		.img_readonly_i (img_readonly_i),
		.img_size_i     (img_size_i),
		.stat_o         (stat_o)
	);

	head_stepper u_head_stepper (
		.clk           (clk),
		.drv_reset_i   (drv_reset_o),
		.mount_i       (mount_i),
		.ctrl_i        (ctrl_i),
		.track_o       (track_o),
		.save_toggle_o (save_toggle),
		.load_toggle_o (load_toggle)
	);

	track_loader u_track_loader (
		.clk           (clk),
		.drv_reset_i   (drv_reset_o),
		.drv_mode_i    (drv_mode_i),
		.track_i       (track_o),
		.save_toggle_i (save_toggle),
		.load_toggle_i (load_toggle),
		.sd_ack_i      (sd_ack_i),
		.sd_o          (sd_o),
		.busy_o        (busy)
	);

	// lit while the controller is active or a track is moving
	assign led_o = ctrl_i.act | busy;

endmodule

// ==== verilog/track_loader.sv ====
// track storage sequencer
// turns save and load toggles into storage writes and reads with block addresses
`timescale 1ns/1ns

module track_loader (
	input  logic                     clk,
	input  logic                     drv_reset_i,
	input  logic [1:0]               drv_mode_i,
	input  logic [7:0]               track_i,
	input  logic                     save_toggle_i,
	input  logic                     load_toggle_i,
	input  logic                     sd_ack_i,
	output drive_types_pkg::sd_req_t sd_o,
	output logic                     busy_o
);
	import drive_cfg_pkg::*;

	typedef enum logic [1:0] {ST_IDLE, ST_REQ, ST_WAIT} state_t;

	state_t      state;
	logic        save_q;
	logic        load_q;
	logic        save_pend;
	logic        load_pend;
	logic [7:0]  save_trk;
	logic [7:0]  load_trk;
	logic [5:0]  blk_cnt;
	logic [31:0] lba;
	logic        rd;
	logic        wr;
	logic        issue_save;
	logic        issue_load;

	always_comb begin
		case (drv_mode_i)
			MODE_1541:                       blk_cnt = BLK_CNT_1541;
			MODE_1570, MODE_1571, MODE_1581: blk_cnt = BLK_CNT_157X;
		endcase
	end

	// next transaction starts only after the previous ack dropped
	assign issue_save = state == ST_IDLE && !sd_ack_i && save_pend;
	assign issue_load = state == ST_IDLE && !sd_ack_i && !save_pend && load_pend;

	// --------------------------------------------------
	// request FSM
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (drv_reset_i) begin
			state     <= ST_IDLE;
			save_q    <= 1'b0;
			load_q    <= 1'b0;
			save_pend <= 1'b0;
			load_pend <= 1'b0;
			rd        <= 1'b0;
			wr        <= 1'b0;
		end else begin
			save_q <= save_toggle_i;
			load_q <= load_toggle_i;
			case (state)
				ST_IDLE: begin
					if (issue_save) begin
						wr        <= 1'b1;
						save_pend <= 1'b0;
						state     <= ST_REQ;
					end else if (issue_load) begin
						rd        <= 1'b1;
						load_pend <= 1'b0;
						state     <= ST_REQ;
					end
				end
				ST_REQ: begin
					if (sd_ack_i) begin
						rd    <= 1'b0;
						wr    <= 1'b0;
						state <= ST_WAIT;
					end
				end
				ST_WAIT: begin
					if (!sd_ack_i)
						state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
			// new toggle edges win over a same-cycle issue, repeats merge
			if (save_toggle_i != save_q)
				save_pend <= 1'b1;
			if (load_toggle_i != load_q)
				load_pend <= 1'b1;
		end
	end

	// track numbers and address, payload only
	always_ff @(posedge clk) begin
		if (save_toggle_i != save_q)
			save_trk <= track_i;
		if (load_toggle_i != load_q)
			load_trk <= track_i;
		if (issue_save)
			lba <= {24'd0, save_trk} * {26'd0, blk_cnt};
		else if (issue_load)
			lba <= {24'd0, load_trk} * {26'd0, blk_cnt};
	end

	assign busy_o = save_pend | load_pend | (state != ST_IDLE);

	always_comb begin
		sd_o.rd      = rd;
		sd_o.wr      = wr;
		sd_o.lba     = lba;
		sd_o.blk_cnt = blk_cnt;
	end

	assert property (@(posedge clk) !(sd_o.rd && sd_o.wr));

	// request and address hold until the storage side acks
	assert property (@(posedge clk) disable iff (drv_reset_i)
		(rd || wr) && !sd_ack_i |=> (rd || wr) && $stable(lba));

endmodule

// ==== verilog/head_stepper.sv ====
// head stepper tracking
// follows stepper phases to keep head track and side, raises save and load toggles
`timescale 1ns/1ns

module head_stepper (
	input  logic                        clk,
	input  logic                        drv_reset_i,
	input  logic                        mount_i,
	input  drive_types_pkg::mech_ctrl_t ctrl_i,
	output logic [7:0]                  track_o,
	output logic                        save_toggle_o,
	output logic                        load_toggle_o
);
	import drive_cfg_pkg::*;

	logic [1:0] stp_old;
	logic [1:0] move;
	logic       side_old;
	logic       mount_q;
	logic [6:0] half_track;
	logic       modified;
	logic       save_tgl;
	logic       load_tgl;
	logic [7:0] track_nxt;
	logic       step_in;
	logic       step_out;
	logic       side_chg;
	logic       mount_edge;

	// --------------------------------------------------
	// phase and side history
	// --------------------------------------------------
	// phase difference registered, move applies a cycle later
	always_ff @(posedge clk) begin
		stp_old  <= ctrl_i.stp;
		move     <= ctrl_i.stp - stp_old;
		side_old <= ctrl_i.side;
		mount_q  <= mount_i;
		track_o  <= track_nxt;
	end

	// +1 is inward, +3 (i.e. -1) is outward
	assign step_in    = ctrl_i.mtr & (move == 2'd1);
	assign step_out   = ctrl_i.mtr & (move == 2'd3);
	assign side_chg   = ctrl_i.side != side_old;
	assign mount_edge = mount_i & ~mount_q;

	// registered side, so a save still sees the track being left
	assign track_nxt = {1'b0, half_track} + (side_old ? SIDE_OFFSET : 8'd0);

	// --------------------------------------------------
	// head position and track requests
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (drv_reset_i) begin
			half_track <= TRACK_START;
			modified   <= 1'b0;
			save_tgl   <= 1'b0;
			load_tgl   <= 1'b0;
		end else begin
			// clamp at both ends of the disk
			if (step_in && half_track < TRACK_MAX)
				half_track <= half_track + 7'd1;
			else if (step_out && half_track != '0)
				half_track <= half_track - 7'd1;

			if (ctrl_i.write)
				modified <= 1'b1;
			// fresh disk, old buffer is gone
			if (mount_edge)
				modified <= 1'b0;

			// leaving a dirty track or activity stopping
			if (modified && (step_in || step_out || side_chg ||
					(!ctrl_i.write && !ctrl_i.act))) begin
				save_tgl <= ~save_tgl;
				modified <= 1'b0;
			end

			// new track under the head or new disk
			if (track_nxt != track_o || mount_edge)
				load_tgl <= ~load_tgl;
		end
	end

	assign save_toggle_o = save_tgl;
	assign load_toggle_o = load_tgl;

	assert property (@(posedge clk) disable iff (drv_reset_i)
		half_track <= TRACK_MAX);

endmodule

// ==== verilog/mode_reset.sv ====
// drive mode change reset
// samples the mode on drive ticks and holds the drive in reset after a change
`timescale 1ns/1ns

module mode_reset (
	input  logic       clk,
	input  logic       reset,
	input  logic       tick_i,
	input  logic [1:0] drv_mode_i,
	output logic       drv_reset_o
);
	import drive_cfg_pkg::*;

	logic [1:0] last_mode;
	logic [7:0] hold_cnt;
	logic       mode_chg;

	always_ff @(posedge clk) begin
		if (reset) begin
			// start from the current mode, no change pending
			last_mode <= drv_mode_i;
			hold_cnt  <= '0;
			mode_chg  <= 1'b0;
		end else if (tick_i) begin
			last_mode <= drv_mode_i;
			if (last_mode != drv_mode_i) begin
				hold_cnt <= RESET_HOLD_TICKS;
				mode_chg <= 1'b1;
			end else if (hold_cnt != '0) begin
				hold_cnt <= hold_cnt - 8'd1;
			end else begin
				// released one tick after the count ran out
				mode_chg <= 1'b0;
			end
		end
	end

	assign drv_reset_o = reset | mode_chg;

	assert property (@(posedge clk) reset |-> drv_reset_o);

endmodule

// ==== verilog/disk_change.sv ====
// disk change detector
// latches image protection and presence on mount, blinks write protect during change
`timescale 1ns/1ns

module disk_change (
	input  logic                        clk,
	input  logic                        reset,
	input  logic                        tick_i,
	input  logic                        mount_i,
	input  logic                        img_readonly_i,
	input  logic [31:0]                 img_size_i,
	output drive_types_pkg::disk_stat_t stat_o
);
	import drive_cfg_pkg::*;

	logic        mount_q;
	logic        mount_edge;
	logic        readonly;
	logic        present;
	logic [23:0] chg_cnt;

	always_ff @(posedge clk) begin
		if (reset) begin
			mount_q    <= 1'b0;
			mount_edge <= 1'b0;
			readonly   <= 1'b0;
			present    <= 1'b0;
			chg_cnt    <= '0;
		end else begin
			// registered rising edge of the mount level
			mount_q    <= mount_i;
			mount_edge <= mount_i & ~mount_q;
			if (mount_edge) begin
				readonly <= img_readonly_i;
				// empty image means no disk
				present  <= |img_size_i;
				chg_cnt  <= CHANGE_TICKS;
			end else if (tick_i && chg_cnt != '0) begin
				chg_cnt <= chg_cnt - 24'd1;
			end
		end
	end

	// counter bit is zero once the window is over
	always_comb begin
		stat_o.present       = present;
		stat_o.readonly      = readonly;
		stat_o.write_protect = readonly ^ chg_cnt[CHANGE_BLINK_BIT];
	end

	// presence only moves two cycles after a mount edge
	assert property (@(posedge clk) disable iff (reset)
		$changed(present) |-> $past(mount_i, 2) && !$past(mount_q, 2));

endmodule

// ==== verilog/drive_types_pkg.sv ====
// drive data types
// bundles between drive controller, mechanics and storage side

package drive_types_pkg;

	// drive signals coming out of the controller
	typedef struct packed {
		// stepper motor phase
		logic [1:0] stp;
		logic       mtr;
		logic       side;
		// activity, also lights the LED
		logic       act;
		logic       wgate;
		// track buffer was written
		logic       write;
	} mech_ctrl_t;

	// disk status as the controller sees it
	typedef struct packed {
		logic present;
		logic readonly;
		// sense level, blinks during a change
		logic write_protect;
	} disk_stat_t;

	// storage request, plain levels held until ack
	typedef struct packed {
		logic        rd;
		logic        wr;
		logic [31:0] lba;
		logic [5:0]  blk_cnt;
	} sd_req_t;

endpackage

// ==== verilog/drive_cfg_pkg.sv ====
// drive configuration constants
// mode codes, track geometry, storage block counts and drive timing

package drive_cfg_pkg;

	// --------------------------------------------------
	// drive modes
	// --------------------------------------------------
	localparam logic [1:0] MODE_1541 = 2'd0;
	localparam logic [1:0] MODE_1570 = 2'd1;
	localparam logic [1:0] MODE_1571 = 2'd2;
	localparam logic [1:0] MODE_1581 = 2'd3;

	// --------------------------------------------------
	// storage geometry
	// --------------------------------------------------
	// 256-byte blocks per track image
	localparam logic [5:0] BLK_CNT_1541 = 6'd31;
	localparam logic [5:0] BLK_CNT_157X = 6'd52;

	// head position in half-tracks
	localparam logic [6:0] TRACK_MAX   = 7'd84;
	localparam logic [6:0] TRACK_START = 7'd36;

	// second side starts right after the first one
	localparam logic [7:0] SIDE_OFFSET = 8'd84;

	// --------------------------------------------------
	// timing, in drive ticks
	// --------------------------------------------------
	// reset stretch after a mode switch
	localparam logic [7:0] RESET_HOLD_TICKS = 8'd255;

	// disk change window
	localparam logic [23:0] CHANGE_TICKS = 24'd64;

	// counter bit that toggles the write protect sense
	localparam int CHANGE_BLINK_BIT = 3;

endpackage
